//--- src/obj_pkg.sv
// sprite layer definitions
package obj_pkg;

    // sprite table geometry
    localparam int OBJ_N      = 64;
    localparam int OBJ_WORDS  = 4;
    localparam int OBJ_IDX_W  = $clog2(OBJ_N);
    localparam int WORD_SEL_W = $clog2(OBJ_WORDS);
    // word address of the object ram, entry index then word
    localparam int RAM_AW     = 8;
    localparam int OBJ_SIZE   = 16;
    localparam int SUB_W      = $clog2(OBJ_SIZE);

    // graphics rom word address is code, row, half
    localparam int ROM_AW     = 17;
    localparam int CODE_W     = 12;

    // pixel fields
    localparam int PAL_W      = 5;
    localparam int PEN_W      = 4;
    localparam int PRIO_W     = 2;
    localparam int LINE_W     = 9;
    // line buffer entry is shadow, priority, palette, pen
    localparam int LB_W       = 12;

    // words of one table entry
    localparam logic [WORD_SEL_W-1:0] WORD_Y    = 2'd0;
    localparam logic [WORD_SEL_W-1:0] WORD_X    = 2'd1;
    localparam logic [WORD_SEL_W-1:0] WORD_CODE = 2'd2;
    localparam logic [WORD_SEL_W-1:0] WORD_ATTR = 2'd3;

    // bit positions inside the y and attribute words
    localparam int Y_ENA         = 15;
    localparam int ATTR_HFLIP    = 8;
    localparam int ATTR_SHD      = 9;
    localparam int ATTR_PRIO_LSB = 10;

    // scanner states
    localparam logic [2:0] SC_IDLE = 3'd0;
    localparam logic [2:0] SC_Y    = 3'd1;
    localparam logic [2:0] SC_YCHK = 3'd2;
    localparam logic [2:0] SC_X    = 3'd3;
    localparam logic [2:0] SC_CODE = 3'd4;
    localparam logic [2:0] SC_ATTR = 3'd5;
    localparam logic [2:0] SC_DRAW = 3'd6;

    // draw engine states
    localparam logic [1:0] DR_IDLE  = 2'd0;
    localparam logic [1:0] DR_ROM   = 2'd1;
    localparam logic [1:0] DR_GAP   = 2'd2;
    localparam logic [1:0] DR_WRITE = 2'd3;

endpackage

//--- src/obj_draw_if.sv
// sprite draw request
`timescale 1ns/1ps
interface obj_draw_if;
    import obj_pkg::*;

    // one clock strobe, fields valid with it
    logic              draw;
    // high from the clock after draw until the last pixel
    logic              busy;
    logic [CODE_W-1:0] code;
    logic [LINE_W-1:0] xpos;
    // row inside the sprite
    logic [SUB_W-1:0]  ysub;
    logic              hflip;
    logic [PAL_W-1:0]  pal;
    logic [PRIO_W-1:0] prio;
    logic              shd;

    // scanner side
    modport scan (output draw, code, xpos, ysub, hflip, pal, prio, shd, input busy);
    // draw engine side
    modport engine (input draw, code, xpos, ysub, hflip, pal, prio, shd, output busy);

endinterface

//--- src/obj_ram.sv
// sprite table ram
`timescale 1ns/1ps
module obj_ram (
    input  logic                       clk,

    // cpu port
    input  logic                       ram_cs,
    input  logic [1:0]                 ram_we,
    input  logic [obj_pkg::RAM_AW-1:0] ram_addr,
    input  logic [15:0]                ram_din,
    output logic [15:0]                cpu_din,

    // scanner port, read only
    input  logic [obj_pkg::RAM_AW-1:0] scan_addr,
    output logic [15:0]                scan_data
);
    import obj_pkg::*;

    logic [15:0] mem [1<<RAM_AW];
    logic [1:0]  we;

    // byte strobes only count with the chip select
    assign we = ram_we & {2{ram_cs}};

    always_ff @(posedge clk) begin
        // low byte
        if (we[0]) begin
            mem[ram_addr][7:0] <= ram_din[7:0];
        end
        // high byte
        if (we[1]) begin
            mem[ram_addr][15:8] <= ram_din[15:8];
        end
        // both reads one clock behind the address
        cpu_din   <= mem[ram_addr];
        scan_data <= mem[scan_addr];
    end

endmodule

//--- src/obj_scan.sv
// sprite table scanner
`timescale 1ns/1ps
module obj_scan (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       hs,
    input  logic [obj_pkg::LINE_W-1:0] vdump,
    // control register
    input  logic                       reg_we,
    input  logic [15:0]                reg_din,
    // object ram
    output logic [obj_pkg::RAM_AW-1:0] scan_addr,
    input  logic [15:0]                scan_data,
    obj_draw_if.scan                   dr
);
    import obj_pkg::*;

    logic [15:0]           ctrl;
    logic                  hs_l;
    logic                  start;
    logic [2:0]            st;
    logic [OBJ_IDX_W-1:0]  idx;
    logic                  last;
    logic [WORD_SEL_W-1:0] wsel;
    logic [LINE_W-1:0]     vline;
    logic [LINE_W-1:0]     ydiff;
    logic                  hit;

    assign start     = hs && !hs_l;
    assign last      = &idx;
    assign scan_addr = {idx, wsel};

    // signed offset in ctrl[15:8] moves every sprite
    assign ydiff = vline - (scan_data[LINE_W-1:0] + {ctrl[15], ctrl[15:8]});
    assign hit   = scan_data[Y_ENA] && (ydiff < LINE_W'(OBJ_SIZE));

    // address one word ahead of the data coming back
    always_comb begin
        case (st)
            SC_YCHK: wsel = WORD_X;
            SC_X:    wsel = WORD_CODE;
            SC_CODE: wsel = WORD_ATTR;
            default: wsel = WORD_Y;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl    <= '0;
            hs_l    <= 1'b0;
            st      <= SC_IDLE;
            idx     <= '0;
            dr.draw <= 1'b0;
        end else begin
            hs_l    <= hs;
            dr.draw <= 1'b0;
            if (reg_we) begin
                ctrl <= reg_din;
            end
            if (start) begin
                // new line, walk from entry 0 if enabled
                idx <= '0;
                st  <= ctrl[0] ? SC_Y : SC_IDLE;
            end else begin
                case (st)
                    SC_Y:    st <= SC_YCHK;
                    SC_YCHK: begin
                        // skip disabled or off-line entries
                        if (hit) begin
                            st <= SC_X;
                        end else begin
                            st  <= last ? SC_IDLE : SC_Y;
                            idx <= idx + 1'b1;
                        end
                    end
                    SC_X:    st <= SC_CODE;
                    SC_CODE: st <= SC_ATTR;
                    SC_ATTR: st <= SC_DRAW;
                    SC_DRAW: begin
                        // wait for the engine
                        if (!dr.busy) begin
                            dr.draw <= ctrl[0];
                            st      <= last ? SC_IDLE : SC_Y;
                            idx     <= idx + 1'b1;
                        end
                    end
                    default: st <= SC_IDLE;
                endcase
            end
        end
    end

    // request fields, captured as the words arrive
    always_ff @(posedge clk) begin
        if (start) begin
            vline <= vdump + 1'b1;
        end
        case (st)
            SC_YCHK: dr.ysub <= ydiff[SUB_W-1:0];
            SC_X:    dr.xpos <= scan_data[LINE_W-1:0];
            SC_CODE: dr.code <= scan_data[CODE_W-1:0];
            SC_ATTR: begin
                dr.pal   <= scan_data[PAL_W-1:0];
                dr.hflip <= scan_data[ATTR_HFLIP];
                dr.shd   <= scan_data[ATTR_SHD];
                dr.prio  <= scan_data[ATTR_PRIO_LSB +: PRIO_W];
            end
            default: ;
        endcase
    end

endmodule

//--- src/obj_draw.sv
// sprite row draw engine
`timescale 1ns/1ps
module obj_draw (
    input  logic                       clk,
    input  logic                       rst_n,
    obj_draw_if.engine                 dr,
    // graphics rom
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    output logic                       rom_cs,
    input  logic                       rom_ok,
    input  logic [31:0]                rom_data,
    // line buffer write side
    output logic                       lb_we,
    output logic [obj_pkg::LINE_W-1:0] lb_addr,
    output logic [obj_pkg::LB_W-1:0]   lb_data
);
    import obj_pkg::*;

    logic [1:0]                 st;
    logic                       half;
    logic [SUB_W-1:0]           cnt;
    logic [CODE_W-1:0]          code_r;
    logic [SUB_W-1:0]           ysub_r;
    logic [LINE_W-1:0]          xpos_r;
    logic [PAL_W-1:0]           pal_r;
    logic [PRIO_W-1:0]          prio_r;
    logic                       shd_r;
    logic                       hflip_r;
    logic [31:0]                row_lo;
    logic [OBJ_SIZE*PEN_W-1:0]  row;
    logic [OBJ_SIZE*PEN_W-1:0]  row_rev;
    logic [OBJ_SIZE*PEN_W-1:0]  pix;

    assign dr.busy  = st != DR_IDLE;
    // held until the rom answers
    assign rom_cs   = st == DR_ROM;
    assign rom_addr = {code_r, ysub_r, half};

    // left half in the low word, low nibble leftmost
    assign row = {rom_data, row_lo};
    always_comb begin
        for (int i = 0; i < OBJ_SIZE; i++) begin
            row_rev[PEN_W*i +: PEN_W] = row[PEN_W*(OBJ_SIZE-1-i) +: PEN_W];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st   <= DR_IDLE;
            half <= 1'b0;
            cnt  <= '0;
        end else begin
            case (st)
                DR_IDLE: if (dr.draw) begin
                    st   <= DR_ROM;
                    half <= 1'b0;
                end
                DR_ROM: if (rom_ok) begin
                    // cs drops for a clock between halves
                    st   <= half ? DR_WRITE : DR_GAP;
                    half <= 1'b1;
                    cnt  <= '0;
                end
                DR_GAP: st <= DR_ROM;
                default: begin
                    cnt <= cnt + 1'b1;
                    if (&cnt) begin
                        st <= DR_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == DR_IDLE && dr.draw) begin
            code_r  <= dr.code;
            ysub_r  <= dr.ysub;
            xpos_r  <= dr.xpos;
            pal_r   <= dr.pal;
            prio_r  <= dr.prio;
            shd_r   <= dr.shd;
            hflip_r <= dr.hflip;
        end
        if (rom_cs && rom_ok) begin
            if (!half) begin
                row_lo <= rom_data;
            end else begin
                pix <= hflip_r ? row_rev : row;
            end
        end
        // one pixel out per write clock
        if (st == DR_WRITE) begin
            pix <= pix >> PEN_W;
        end
    end

    // pen 0 is transparent, never written
    assign lb_we   = (st == DR_WRITE) && (pix[PEN_W-1:0] != '0);
    assign lb_addr = xpos_r + LINE_W'(cnt);
    assign lb_data = {shd_r, prio_r, pal_r, pix[PEN_W-1:0]};

endmodule

//--- src/obj_linebuf.sv
// ping-pong sprite line buffer
`timescale 1ns/1ps
module obj_linebuf (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       pxl_cen,
    input  logic                                       hs,
    input  logic [obj_pkg::LINE_W-1:0]                 hdump,
    input  logic                                       lb_we,
    input  logic [obj_pkg::LINE_W-1:0]                 lb_addr,
    input  logic [obj_pkg::LB_W-1:0]                   lb_data,
    output logic [obj_pkg::PAL_W+obj_pkg::PEN_W-1:0]   pxl,
    output logic                                       shd,
    output logic [obj_pkg::PRIO_W-1:0]                 prio
);
    import obj_pkg::*;

    logic              hs_l;
    logic              wr_bank;
    logic              sweep;
    logic [LINE_W-1:0] sweep_addr;
    logic [LB_W-1:0]   rd_data [2];
    logic [LB_W-1:0]   play_q;
    logic [PEN_W-1:0]  pen;
    logic              is_shd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_l       <= 1'b0;
            wr_bank    <= 1'b0;
            sweep      <= 1'b1;
            sweep_addr <= '0;
        end else begin
            hs_l <= hs;
            // swap draw and playout banks
            if (hs && !hs_l) begin
                wr_bank <= ~wr_bank;
            end
            // clear both banks once after reset
            if (sweep) begin
                sweep_addr <= sweep_addr + 1'b1;
                sweep      <= ~&sweep_addr;
            end
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [LB_W-1:0]   mem [1<<LINE_W];
        logic [LINE_W-1:0] waddr;
        logic [LB_W-1:0]   wdata;
        logic              wen;

        always_comb begin
            // playout bank clears each position as it goes out
            waddr = hdump;
            wdata = '0;
            wen   = pxl_cen;
            if (sweep) begin
                waddr = sweep_addr;
                wen   = 1'b1;
            end else if (wr_bank == 1'(b)) begin
                // first opaque pen wins, so lower sprites stay on top
                waddr = lb_addr;
                wdata = lb_data;
                wen   = lb_we && (mem[lb_addr][PEN_W-1:0] == '0);
            end
        end

        always_ff @(posedge clk) begin
            if (wen) begin
                mem[waddr] <= wdata;
            end
        end

        assign rd_data[b] = mem[hdump];
    end

    // shadow flag with pen 15 means shadow only
    assign pen    = play_q[PEN_W-1:0];
    assign is_shd = play_q[LB_W-1] && (&pen);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            play_q <= '0;
            pxl    <= '0;
            shd    <= 1'b0;
            prio   <= '0;
        end else begin
            if (pxl_cen) begin
                play_q <= rd_data[~wr_bank];
            end
            // output stage, one clock behind
            pxl  <= {play_q[PEN_W +: PAL_W], is_shd ? {PEN_W{1'b0}} : pen};
            shd  <= is_shd;
            prio <= play_q[PEN_W+PAL_W +: PRIO_W];
        end
    end

endmodule

//--- src/obj_top.sv
// sprite layer top
`timescale 1ns/1ps
module obj_top (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // video timing
    input  logic                                     pxl_cen,
    input  logic [obj_pkg::LINE_W-1:0]               hdump,
    input  logic [obj_pkg::LINE_W-1:0]               vdump,
    input  logic                                     hs,
    // cpu port
    input  logic                                     ram_cs,
    input  logic [1:0]                               ram_we,
    input  logic [obj_pkg::RAM_AW-1:0]               ram_addr,
    input  logic [15:0]                              ram_din,
    output logic [15:0]                              cpu_din,
    input  logic                                     reg_we,
    input  logic [15:0]                              reg_din,
    // graphics rom
    output logic [obj_pkg::ROM_AW-1:0]               rom_addr,
    output logic                                     rom_cs,
    input  logic                                     rom_ok,
    input  logic [31:0]                              rom_data,
    // pixel out
    output logic [obj_pkg::PAL_W+obj_pkg::PEN_W-1:0] pxl,
    output logic                                     shd,
    output logic [obj_pkg::PRIO_W-1:0]               prio
);
    import obj_pkg::*;

    logic [RAM_AW-1:0] scan_addr;
    logic [15:0]       scan_data;
    logic              lb_we;
    logic [LINE_W-1:0] lb_addr;
    logic [LB_W-1:0]   lb_data;

    // scanner to engine request
    obj_draw_if u_dr_if ();

    obj_ram u_ram (
        .clk       ( clk       ),
        .ram_cs    ( ram_cs    ),
        .ram_we    ( ram_we    ),
        .ram_addr  ( ram_addr  ),
        .ram_din   ( ram_din   ),
        .cpu_din   ( cpu_din   ),
        .scan_addr ( scan_addr ),
        .scan_data ( scan_data )
    );

    obj_scan u_scan (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .hs        ( hs        ),
        .vdump     ( vdump     ),
        .reg_we    ( reg_we    ),
        .reg_din   ( reg_din   ),
        .scan_addr ( scan_addr ),
        .scan_data ( scan_data ),
        .dr        ( u_dr_if   )
    );

    obj_draw u_draw (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .dr        ( u_dr_if   ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .rom_ok    ( rom_ok    ),
        .rom_data  ( rom_data  ),
        .lb_we     ( lb_we     ),
        .lb_addr   ( lb_addr   ),
        .lb_data   ( lb_data   )
    );

    obj_linebuf u_linebuf (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .hs        ( hs        ),
        .hdump     ( hdump     ),
        .lb_we     ( lb_we     ),
        .lb_addr   ( lb_addr   ),
        .lb_data   ( lb_data   ),
        .pxl       ( pxl       ),
        .shd       ( shd       ),
        .prio      ( prio      )
    );

endmodule

//--- test/obj_rom_model.sv
// graphics rom model
`timescale 1ns/1ps
module obj_rom_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rom_cs,
    input  logic [16:0] rom_addr,
    output logic        rom_ok,
    output logic [31:0] rom_data
);
    logic [1:0] cnt;

    // data is a fixed scramble of the address
    function automatic logic [31:0] mix(input logic [16:0] a);
        logic [31:0] v;
        v = {15'd0, a} * 32'h9e3779b1;
        return v ^ (v >> 15);
    endfunction

    assign rom_data = mix(rom_addr);

    // ok three clocks after cs, drops with cs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt    <= '0;
            rom_ok <= 1'b0;
        end else if (!rom_cs) begin
            cnt    <= '0;
            rom_ok <= 1'b0;
        end else begin
            if (cnt != 2'd3) begin
                cnt <= cnt + 2'd1;
            end
            rom_ok <= cnt == 2'd2;
        end
    end

endmodule

//--- test/obj_tb.sv
// sprite layer testbench
`timescale 1ns/1ps
module obj_tb;
    localparam int N_TESTS = 6;
    localparam int LINE_NS = 384 * 2 * 10;
    // four lines per test plus reset and sweep
    localparam int TIMEOUT = (N_TESTS * 4 + 4) * LINE_NS;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic [8:0]  hdump;
    logic [8:0]  vdump;
    logic        hs;
    logic        ram_cs;
    logic [1:0]  ram_we;
    logic [7:0]  ram_addr;
    logic [15:0] ram_din;
    logic [15:0] cpu_din;
    logic        reg_we;
    logic [15:0] reg_din;
    logic [16:0] rom_addr;
    logic        rom_cs;
    logic        rom_ok;
    logic [31:0] rom_data;
    logic [8:0]  pxl;
    logic        shd;
    logic [1:0]  prio;

    // copy of the sprite table, and expected and captured lines
    logic [15:0] ty [64];
    logic [15:0] tx [64];
    logic [15:0] tcode [64];
    logic [15:0] tattr [64];
    logic [11:0] exp_lb [512];
    logic [8:0]  got_pxl [512];
    logic        got_shd [512];
    logic [1:0]  got_prio [512];
    int          errors;
    int          failed_tests;
    int          seed_val;
    // rom request seen waiting in the previous clock
    logic        cs_wait;
    logic [16:0] cs_addr;

    obj_top u_obj_top (.*);

    obj_rom_model u_rom (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_ok   ( rom_ok   ),
        .rom_data ( rom_data )
    );

    always #5 clk = ~clk;

    // 384 positions per line, hs over 300..331
    assign hs = (hdump >= 9'd300) && (hdump < 9'd332);

    always @(posedge clk) begin
        #1;
        if (pxl_cen) begin
            if (hdump == 9'd383) begin
                hdump = '0;
                vdump = vdump + 9'd1;
            end else begin
                hdump = hdump + 9'd1;
            end
        end
        pxl_cen = ~pxl_cen;
    end

    // rom request stays up with a stable address until ok
    always @(posedge clk) begin
        #2;
        if (cs_wait) begin
            assert (rom_cs && rom_addr == cs_addr)
            else begin
                $display("CHECK FAILED t=%0t rom request changed before ok, cs %b addr %h",
                         $time, rom_cs, rom_addr);
                errors++;
            end
        end
        cs_wait = rom_cs && !rom_ok;
        cs_addr = rom_addr;
    end

    // same scramble as the rom
    function automatic logic [31:0] rom_word(input logic [16:0] a);
        logic [31:0] v;
        v = {15'd0, a} * 32'h9e3779b1;
        return v ^ (v >> 15);
    endfunction

    function automatic logic [63:0] rom_row(input logic [11:0] code, input logic [3:0] r);
        return {rom_word({code, r, 1'b1}), rom_word({code, r, 1'b0})};
    endfunction

    task automatic ram_write(input logic [7:0] a, input logic [1:0] we, input logic [15:0] d);
        @(posedge clk);
        #1;
        ram_cs   = 1'b1;
        ram_we   = we;
        ram_addr = a;
        ram_din  = d;
        @(posedge clk);
        #1;
        ram_cs = 1'b0;
        ram_we = 2'b00;
    endtask

    task automatic ram_read(input logic [7:0] a, output logic [15:0] d);
        @(posedge clk);
        #1;
        ram_addr = a;
        @(posedge clk);
        #1;
        d = cpu_din;
    endtask

    task automatic ctrl_write(input logic [15:0] d);
        @(posedge clk);
        #1;
        reg_we  = 1'b1;
        reg_din = d;
        @(posedge clk);
        #1;
        reg_we = 1'b0;
    endtask

    task automatic set_sprite(input int i, input logic [15:0] y, input logic [15:0] x,
                              input logic [15:0] code, input logic [15:0] attr);
        ty[i]    = y;
        tx[i]    = x;
        tcode[i] = code;
        tattr[i] = attr;
        ram_write({6'(i), 2'd0}, 2'b11, y);
        ram_write({6'(i), 2'd1}, 2'b11, x);
        ram_write({6'(i), 2'd2}, 2'b11, code);
        ram_write({6'(i), 2'd3}, 2'b11, attr);
    endtask

    task automatic clear_table();
        for (int i = 0; i < 64; i++) begin
            ty[i] = '0;
            ram_write({6'(i), 2'd0}, 2'b11, 16'd0);
        end
    endtask

    // wait for hs, return the line drawn after the next one
    task automatic sync_line(output logic [8:0] target);
        @(posedge hs);
        target = vdump + 9'd2;
    endtask

    // model of scan, draw and line buffer rules
    task automatic build_expected(input logic [8:0] line, input logic [7:0] off,
                                  input logic ena);
        logic [8:0]  ydiff;
        logic [63:0] row;
        logic [3:0]  pen;
        logic [8:0]  pos;
        for (int p = 0; p < 512; p++) begin
            exp_lb[p] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            ydiff = line - (ty[i][8:0] + {off[7], off});
            if (ena && ty[i][15] && ydiff < 9'd16) begin
                row = rom_row(tcode[i][11:0], ydiff[3:0]);
                for (int k = 0; k < 16; k++) begin
                    pen = tattr[i][8] ? row[4*(15-k) +: 4] : row[4*k +: 4];
                    pos = tx[i][8:0] + 9'(k);
                    // first opaque pen stays
                    if (pen != 4'd0 && exp_lb[pos][3:0] == 4'd0) begin
                        exp_lb[pos] = {tattr[i][9], tattr[i][11:10], tattr[i][4:0], pen};
                    end
                end
            end
        end
    endtask

    // skip the partial line, then capture the next whole one
    task automatic get_line();
        logic       c1;
        logic       c2;
        logic [8:0] h1;
        logic [8:0] h2;
        int         n;
        c1 = 1'b0;
        h1 = '0;
        n  = 0;
        repeat (2) @(posedge hs);
        while (n < 384) begin
            @(posedge clk);
            c2 = c1;
            h2 = h1;
            c1 = pxl_cen;
            h1 = hdump;
            #2;
            // output for a sample point shows two clocks later
            if (c2) begin
                got_pxl[h2]  = pxl;
                got_shd[h2]  = shd;
                got_prio[h2] = prio;
                n++;
            end
        end
    endtask

    task automatic check_line(input string name);
        logic [11:0] e;
        logic        eshd;
        logic [8:0]  epxl;
        for (int p = 0; p < 384; p++) begin
            e    = exp_lb[p];
            eshd = e[11] && (e[3:0] == 4'hf);
            epxl = {e[8:4], eshd ? 4'd0 : e[3:0]};
            assert (got_pxl[p] == epxl && got_shd[p] == eshd && got_prio[p] == e[10:9])
            else begin
                $display("CHECK FAILED t=%0t %s pos %0d got %h/%b/%0d exp %h/%b/%0d",
                         $time, name, p, got_pxl[p], got_shd[p], got_prio[p],
                         epxl, eshd, e[10:9]);
                errors++;
            end
        end
    endtask

    task automatic report(input string name, input int start_err);
        if (errors == start_err) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - start_err);
            failed_tests++;
        end
    endtask

    task automatic ram_readback();
        int          e0;
        logic [7:0]  a;
        logic [15:0] base;
        logic [15:0] upd;
        logic [1:0]  st;
        logic [15:0] got;
        logic [15:0] exp;
        e0 = errors;
        for (int n = 0; n < 16; n++) begin
            a    = 8'($urandom);
            base = 16'($urandom);
            upd  = 16'($urandom);
            st   = 2'($urandom);
            ram_write(a, 2'b11, base);
            ram_write(a, st, upd);
            ram_read(a, got);
            exp = {st[1] ? upd[15:8] : base[15:8], st[0] ? upd[7:0] : base[7:0]};
            assert (got == exp)
            else begin
                $display("CHECK FAILED t=%0t ram addr %h got %h exp %h", $time, a, got, exp);
                errors++;
            end
        end
        clear_table();
        report("ram read-back", e0);
    endtask

    task automatic single_sprite();
        int         e0;
        logic [8:0] l;
        e0 = errors;
        sync_line(l);
        clear_table();
        set_sprite(0, {7'h40, l - 9'(3 + $urandom % 13)}, 16'($urandom % 361),
                   16'($urandom % 4096), 16'h0412);
        ctrl_write(16'h0001);
        build_expected(l, 8'd0, 1'b1);
        get_line();
        check_line("single");
        report("single sprite", e0);
    endtask

    task automatic hflip_wrap();
        int         e0;
        logic [8:0] l;
        e0 = errors;
        sync_line(l);
        clear_table();
        // flipped sprite, then one wrapping past 511
        set_sprite(0, {7'h40, l - 9'd5}, 16'($urandom % 300), 16'($urandom % 4096), 16'h0107);
        set_sprite(1, {7'h40, l - 9'd9}, 16'd505, 16'($urandom % 4096), 16'h0809);
        build_expected(l, 8'd0, 1'b1);
        get_line();
        check_line("flip/wrap");
        report("hflip and wrap", e0);
    endtask

    task automatic overlap_priority();
        int         e0;
        logic [8:0] l;
        e0 = errors;
        sync_line(l);
        clear_table();
        set_sprite(0, {7'h40, l - 9'd2}, 16'd100, 16'($urandom % 4096), 16'h0401);
        set_sprite(1, {7'h40, l - 9'd12}, 16'd108, 16'($urandom % 4096), 16'h0802);
        // off the line, and disabled on the line
        set_sprite(2, {7'h40, l + 9'd40}, 16'd200, 16'($urandom % 4096), 16'h0003);
        set_sprite(3, {7'h00, l - 9'd1}, 16'd250, 16'($urandom % 4096), 16'h0004);
        build_expected(l, 8'd0, 1'b1);
        get_line();
        check_line("overlap");
        report("overlap priority", e0);
    endtask

    task automatic shadow_pens();
        int          e0;
        logic [8:0]  l;
        logic [11:0] code;
        logic [63:0] row;
        logic        has15;
        logic        hasother;
        e0   = errors;
        code = 12'($urandom);
        // look for a row 4 with pen 15 and other pens
        for (int t = 0; t < 4096; t++) begin
            row      = rom_row(code, 4'd4);
            has15    = 1'b0;
            hasother = 1'b0;
            for (int k = 0; k < 16; k++) begin
                has15    = has15 | (row[4*k +: 4] == 4'hf);
                hasother = hasother | (row[4*k +: 4] != 4'hf && row[4*k +: 4] != 4'h0);
            end
            if (!(has15 && hasother)) begin
                code = code + 12'd1;
            end
        end
        assert (has15 && hasother)
        else begin
            $display("no rom row with pen 15 found for the shadow test");
            errors++;
        end
        sync_line(l);
        clear_table();
        set_sprite(0, {7'h40, l - 9'd4}, 16'($urandom % 361), {4'd0, code}, 16'h0615);
        build_expected(l, 8'd0, 1'b1);
        get_line();
        check_line("shadow");
        report("shadow rule", e0);
    endtask

    task automatic ctrl_register();
        int         e0;
        logic [8:0] l;
        e0 = errors;
        sync_line(l);
        clear_table();
        set_sprite(0, {7'h40, l - 9'd7}, 16'd60, 16'($urandom % 4096), 16'h0c0a);
        ctrl_write(16'h0000);
        build_expected(l, 8'd0, 1'b0);
        get_line();
        check_line("disabled");
        // offset of -3 moves the row to 10
        sync_line(l);
        set_sprite(0, {7'h40, l - 9'd7}, 16'd60, tcode[0], 16'h0c0a);
        ctrl_write(16'hfd01);
        build_expected(l, 8'hfd, 1'b1);
        get_line();
        check_line("offset");
        report("control register", e0);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        pxl_cen      = 1'b0;
        hdump        = '0;
        vdump        = '0;
        ram_cs       = 1'b0;
        ram_we       = 2'b00;
        ram_addr     = '0;
        ram_din      = '0;
        reg_we       = 1'b0;
        reg_din      = '0;
        cs_wait      = 1'b0;
        cs_addr      = '0;
        errors       = 0;
        failed_tests = 0;
        seed_val     = $urandom(32'hd7b1c9e1);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // line buffer sweep
        repeat (600) @(posedge clk);
        ram_readback();
        single_sprite();
        hflip_wrap();
        overlap_priority();
        shadow_pens();
        ctrl_register();
        $display("tests run %0d, failed %0d, check errors %0d", N_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- compile.f
src/obj_pkg.sv
src/obj_draw_if.sv
src/obj_ram.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_linebuf.sv
src/obj_top.sv
test/obj_rom_model.sv
test/obj_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -j 0
TOP       = obj_tb
FILELIST  = compile.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
